/* flist.f */
+incdir+include
source/branch_pkg.sv
source/branch_calc_if.sv
source/branch_cond_eval.sv
source/branch_target_calc.sv
source/branch_resolve_cu.sv
source/branch_unit.sv
testbench/tb_branch_unit.sv

/* Bender.yml */
package:
  name: branch_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/branch_pkg.sv
      - source/branch_calc_if.sv
      - source/branch_cond_eval.sv
      - source/branch_target_calc.sv
      - source/branch_resolve_cu.sv
      - source/branch_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_branch_unit.sv

/* testbench/tb_branch_unit.sv */
// Self-checking testbench for the branch unit, applies a stimulus table and random traffic

`timescale 1ns/1ps
`default_nettype none

`include "branch_settings.svh"

module tb_branch_unit;

  import branch_pkg::*;

  // Bound for every handshake wait, in cycles
  localparam int WAIT_LIMIT = 50;
  // Back-to-back random instructions
  localparam int BURST_LEN = 20;
  // Frequent table operands
  localparam word_t PC_A      = 32'h0000_1000;
  localparam word_t MINUS_ONE = 32'hFFFF_FFFF;
  localparam word_t MINUS_3   = 32'hFFFF_FFFD;

  // One stimulus row
  typedef struct {
    string      name;
    branch_op_t op;
    word_t      rs1;
    word_t      rs2;
    word_t      imm;
    word_t      pc;
    logic       pred_taken;
    word_t      pred_target;
  } row_t;

  // Expected outputs of one row
  typedef struct {
    string name;
    logic  taken;
    logic  mispredict;
    word_t pc;
    word_t next_pc;
    word_t link;
  } result_t;

  // DUT inputs
  logic       clk_i;
  logic       rst_n_i;
  logic       ops_valid_i;
  branch_op_t op_i;
  word_t      rs1_i;
  word_t      rs2_i;
  word_t      imm_i;
  word_t      pc_i;
  logic       pred_taken_i;
  word_t      pred_target_i;
  logic       res_ready_i;
  // DUT outputs
  logic       ops_ready_o;
  logic       res_valid_o;
  word_t      res_pc_o;
  word_t      res_next_pc_o;
  word_t      res_link_o;
  logic       res_taken_o;
  logic       res_mispredict_o;

  row_t rows[$];

  branch_unit dut0 (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ops_valid_i      (ops_valid_i),
    .op_i             (op_i),
    .rs1_i            (rs1_i),
    .rs2_i            (rs2_i),
    .imm_i            (imm_i),
    .pc_i             (pc_i),
    .pred_taken_i     (pred_taken_i),
    .pred_target_i    (pred_target_i),
    .res_ready_i      (res_ready_i),
    .ops_ready_o      (ops_ready_o),
    .res_valid_o      (res_valid_o),
    .res_pc_o         (res_pc_o),
    .res_next_pc_o    (res_next_pc_o),
    .res_link_o       (res_link_o),
    .res_taken_o      (res_taken_o),
    .res_mispredict_o (res_mispredict_o)
  );

  // 20 ns clock
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Reports the error line and ends the run
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input string what, input word_t exp,
                            input word_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s %s expected %h actual %h", name, what, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s %s expected %b actual %b", name, what, exp, act));
    end
  endtask

  // Branch direction by the ISA rules
  function automatic logic decide_taken(branch_op_t op, word_t a, word_t b);
    case (op)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return $signed(a) < $signed(b);
      BR_BGE:  return $signed(a) >= $signed(b);
      BR_BLTU: return a < b;
      BR_BGEU: return a >= b;
      // Jumps always redirect
      default: return 1'b1;
    endcase
  endfunction

  // PC relative, except JALR which is rs1 relative with the low bit cleared
  function automatic word_t form_target(branch_op_t op, word_t rs1, word_t imm, word_t pc);
    if (op == BR_JALR) begin
      return (rs1 + imm) & ~word_t'(1);
    end
    return pc + imm;
  endfunction

  function automatic result_t expected_result(row_t r);
    result_t e;
    word_t   target;
    target       = form_target(r.op, r.rs1, r.imm, r.pc);
    e.name       = r.name;
    e.taken      = decide_taken(r.op, r.rs1, r.rs2);
    e.pc         = r.pc;
    e.link       = r.pc + word_t'(`BRANCH_ILEN_BYTES);
    // Not taken continues at the sequential successor
    e.next_pc    = e.taken ? target : e.link;
    // Wrong direction, or both taken toward different targets
    if (r.pred_taken != e.taken) begin
      e.mispredict = 1'b1;
    end else if (e.taken) begin
      e.mispredict = (r.pred_target != target);
    end else begin
      e.mispredict = 1'b0;
    end
    return e;
  endfunction

  task automatic add_row(input string name, input branch_op_t op, input word_t rs1,
                         input word_t rs2, input word_t imm, input word_t pc,
                         input logic pred_taken, input word_t pred_target);
    row_t r;
    r.name        = name;
    r.op          = op;
    r.rs1         = rs1;
    r.rs2         = rs2;
    r.imm         = imm;
    r.pc          = pc;
    r.pred_taken  = pred_taken;
    r.pred_target = pred_target;
    rows.push_back(r);
  endtask

  function automatic row_t random_row(int idx);
    row_t        r;
    logic [31:0] bits;
    r.name = $sformatf("random_%0d", idx);
    r.op   = branch_op_t'(4'($urandom % 8));
    r.rs1  = $urandom;
    // Equal operands now and then so BEQ and BNE see both outcomes
    r.rs2  = ($urandom % 4 == 0) ? r.rs1 : $urandom;
    bits   = $urandom;
    // Sign-extended even offset within +-2 KiB
    r.imm  = {{20{bits[11]}}, bits[11:1], 1'b0};
    r.pc   = $urandom & 32'hFFFF_FFFC;
    r.pred_taken  = ($urandom % 2) != 0;
    r.pred_target = (($urandom % 2) != 0) ? form_target(r.op, r.rs1, r.imm, r.pc) : $urandom;
    return r;
  endfunction

  // Call right after a rising edge
  task automatic present_row(input row_t r);
    op_i          <= r.op;
    rs1_i         <= r.rs1;
    rs2_i         <= r.rs2;
    imm_i         <= r.imm;
    pc_i          <= r.pc;
    pred_taken_i  <= r.pred_taken;
    pred_target_i <= r.pred_target;
  endtask

  // Returns on the falling edge where ops_ready_o is high
  task automatic wait_ops_ready(input string name);
    int n;
    n = 0;
    @(negedge clk_i);
    while (ops_ready_o !== 1'b1) begin
      if (n >= WAIT_LIMIT) begin
        abort_run($sformatf("Timeout: ops_ready_o never rose for %s", name));
      end
      n++;
      @(negedge clk_i);
    end
  endtask

  task automatic compare_result(input result_t e);
    check_flag(e.name, "res_taken_o", e.taken, res_taken_o);
    check_flag(e.name, "res_mispredict_o", e.mispredict, res_mispredict_o);
    check_word(e.name, "res_pc_o", e.pc, res_pc_o);
    check_word(e.name, "res_next_pc_o", e.next_pc, res_next_pc_o);
    check_word(e.name, "res_link_o", e.link, res_link_o);
  endtask

  // One row with a random stall before the result is consumed
  task automatic apply_single(input row_t r);
    result_t e;
    row_t    other;
    int      hold;
    e = expected_result(r);
    // Shifted PC and rs1 move every computed address while the result waits
    other     = r;
    other.pc  = r.pc + 32'h100;
    other.rs1 = r.rs1 + 32'h100;
    @(posedge clk_i);
    present_row(r);
    ops_valid_i <= 1'b1;
    wait_ops_ready(r.name);
    // Accepted on this edge
    @(posedge clk_i);
    ops_valid_i <= 1'b0;
    present_row(other);
    @(negedge clk_i);
    check_flag(r.name, "res_valid_o one cycle after accept", 1'b1, res_valid_o);
    hold = 1 + ($urandom % 5);
    for (int i = 0; i < hold; i++) begin
      check_flag(r.name, "ops_ready_o while stalled", 1'b0, ops_ready_o);
      check_word(r.name, "held res_pc_o", e.pc, res_pc_o);
      check_word(r.name, "held res_next_pc_o", e.next_pc, res_next_pc_o);
      @(negedge clk_i);
    end
    check_flag(r.name, "res_valid_o after stall", 1'b1, res_valid_o);
    compare_result(e);
    @(posedge clk_i);
    res_ready_i <= 1'b1;
    // Consumed on this edge
    @(posedge clk_i);
    res_ready_i <= 1'b0;
    @(negedge clk_i);
    check_flag(r.name, "res_valid_o after consume", 1'b0, res_valid_o);
  endtask

  // Random rows on consecutive cycles with the consumer always ready
  task automatic run_back_to_back(input int count);
    row_t    issued[$];
    row_t    r;
    result_t e;
    @(posedge clk_i);
    res_ready_i <= 1'b1;
    for (int k = 0; k <= count; k++) begin
      @(posedge clk_i);
      if (k < count) begin
        r = random_row(k);
        present_row(r);
        ops_valid_i <= 1'b1;
        issued.push_back(r);
      end else begin
        ops_valid_i <= 1'b0;
      end
      @(negedge clk_i);
      if (k < count) begin
        check_flag(r.name, "ops_ready_o at full rate", 1'b1, ops_ready_o);
      end
      // Previous row was accepted on the last edge
      if (k > 0) begin
        e = expected_result(issued.pop_front());
        check_flag(e.name, "res_valid_o in order", 1'b1, res_valid_o);
        compare_result(e);
      end
    end
    @(posedge clk_i);
    @(negedge clk_i);
    check_flag("burst_drain", "res_valid_o after last result", 1'b0, res_valid_o);
    res_ready_i <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h5158667e));
    rst_n_i       = 1'b0;
    ops_valid_i   = 1'b0;
    op_i          = BR_BEQ;
    rs1_i         = '0;
    rs2_i         = '0;
    imm_i         = '0;
    pc_i          = '0;
    pred_taken_i  = 1'b0;
    pred_target_i = '0;
    res_ready_i   = 1'b0;

    // Conditional branches, each with equal, signed-smaller and sign-split operands
    add_row("beq_equal", BR_BEQ, 32'd5, 32'd5, 32'h40, PC_A, 1'b1, 32'h1040);
    add_row("beq_signed_less", BR_BEQ, MINUS_3, 32'd2, 32'h40, PC_A, 1'b0, 32'hDEAD_BEE0);
    add_row("beq_sign_split", BR_BEQ, MINUS_ONE, 32'd1, 32'h40, PC_A, 1'b0, 32'h0);
    add_row("bne_equal_wrong_dir", BR_BNE, 32'd5, 32'd5, 32'h40, PC_A, 1'b1, 32'h1040);
    add_row("bne_wrong_target", BR_BNE, MINUS_3, 32'd2, 32'h40, PC_A, 1'b1, 32'h1080);
    add_row("bne_sign_split", BR_BNE, MINUS_ONE, 32'd1, 32'h40, PC_A, 1'b1, 32'h1040);
    add_row("blt_equal", BR_BLT, 32'd5, 32'd5, 32'h40, PC_A, 1'b0, 32'h0);
    add_row("blt_signed_less", BR_BLT, MINUS_3, 32'd2, 32'hFFFF_FFE0, 32'h2000, 1'b1,
            32'h1FE0);
    add_row("blt_sign_split", BR_BLT, MINUS_ONE, 32'd1, 32'h40, PC_A, 1'b0, 32'h0);
    add_row("bge_equal", BR_BGE, 32'd5, 32'd5, 32'h40, PC_A, 1'b1, 32'h1040);
    add_row("bge_signed_less", BR_BGE, MINUS_3, 32'd2, 32'h40, PC_A, 1'b0, 32'h0);
    add_row("bge_sign_split", BR_BGE, MINUS_ONE, 32'd1, 32'h40, PC_A, 1'b1, 32'h1040);
    add_row("bltu_equal", BR_BLTU, 32'd5, 32'd5, 32'h40, PC_A, 1'b0, 32'h0);
    add_row("bltu_signed_less", BR_BLTU, MINUS_3, 32'd2, 32'h40, PC_A, 1'b0, 32'h0);
    add_row("bltu_sign_split", BR_BLTU, MINUS_ONE, 32'd1, 32'h40, PC_A, 1'b1, 32'h1040);
    add_row("bgeu_equal", BR_BGEU, 32'd5, 32'd5, 32'h40, PC_A, 1'b1, 32'h1040);
    add_row("bgeu_signed_less", BR_BGEU, MINUS_3, 32'd2, 32'h40, PC_A, 1'b1, 32'h1040);
    add_row("bgeu_sign_split", BR_BGEU, MINUS_ONE, 32'd1, 32'h40, PC_A, 1'b0, 32'h0);
    // Jumps, JALR with odd sums to exercise the low bit clear
    add_row("jal_forward", BR_JAL, 32'd0, 32'd0, 32'h100, 32'h3000, 1'b1, 32'h3100);
    add_row("jal_back_wrong_dir", BR_JAL, 32'd0, 32'd0, 32'hFFFF_FF00, 32'h3000, 1'b0, 32'h0);
    add_row("jalr_even", BR_JALR, 32'h8000, 32'd0, 32'h10, 32'h4000, 1'b1, 32'h8010);
    add_row("jalr_odd_rs1", BR_JALR, 32'h8001, 32'd0, 32'h10, 32'h4000, 1'b1, 32'h8011);
    add_row("jalr_odd_imm", BR_JALR, 32'h8000, 32'd0, MINUS_ONE, 32'h4000, 1'b1, 32'h7FFE);

    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_flag("reset", "res_valid_o", 1'b0, res_valid_o);
    check_flag("reset", "ops_ready_o", 1'b1, ops_ready_o);

    foreach (rows[i]) begin
      apply_single(rows[i]);
    end
    run_back_to_back(BURST_LEN);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* source/branch_unit.sv */
// Top level of the execution-stage branch unit, connecting evaluator, target calculator and control

`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  // Instruction and operands
  input  wire logic                   ops_valid_i,
  input  wire branch_pkg::branch_op_t op_i,
  input  wire branch_pkg::word_t      rs1_i,
  input  wire branch_pkg::word_t      rs2_i,
  input  wire branch_pkg::word_t      imm_i,
  input  wire branch_pkg::word_t      pc_i,
  // Front end prediction
  input  wire logic                   pred_taken_i,
  input  wire branch_pkg::word_t      pred_target_i,
  // Consumer back-pressure
  input  wire logic                   res_ready_i,
  output logic                        ops_ready_o,
  // Resolved result
  output logic                        res_valid_o,
  output branch_pkg::word_t           res_pc_o,
  output branch_pkg::word_t           res_next_pc_o,
  output branch_pkg::word_t           res_link_o,
  output logic                        res_taken_o,
  output logic                        res_mispredict_o
);

  // Same-cycle results of the two combinational blocks
  branch_calc_if calc_if ();

  // Direction
  branch_cond_eval u_cond_eval (
    .rs1_i (rs1_i),
    .rs2_i (rs2_i),
    .op_i  (op_i),
    .calc  (calc_if.eval)
  );

  // Target and return address
  branch_target_calc u_target_calc (
    .rs1_i (rs1_i),
    .imm_i (imm_i),
    .pc_i  (pc_i),
    .op_i  (op_i),
    .calc  (calc_if.calc)
  );

  // Prediction check, output register and handshakes
  branch_resolve_cu u_resolve_cu (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ops_valid_i      (ops_valid_i),
    .pred_taken_i     (pred_taken_i),
    .pred_target_i    (pred_target_i),
    .pc_i             (pc_i),
    .ops_ready_o      (ops_ready_o),
    .calc             (calc_if.cu),
    .res_ready_i      (res_ready_i),
    .res_valid_o      (res_valid_o),
    .res_taken_o      (res_taken_o),
    .res_mispredict_o (res_mispredict_o),
    .res_pc_o         (res_pc_o),
    .res_next_pc_o    (res_next_pc_o),
    .res_link_o       (res_link_o)
  );

endmodule

`default_nettype wire

/* source/branch_resolve_cu.sv */
// Resolution control unit that checks the prediction, registers the result and handles the handshakes

`timescale 1ns/1ps
`default_nettype none

module branch_resolve_cu (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  // Operand side
  input  wire logic              ops_valid_i,
  input  wire logic              pred_taken_i,
  input  wire branch_pkg::word_t pred_target_i,
  input  wire branch_pkg::word_t pc_i,
  output logic                   ops_ready_o,
  // Results of the two combinational blocks
  branch_calc_if.cu              calc,
  // Result side
  input  wire logic              res_ready_i,
  output logic                   res_valid_o,
  output logic                   res_taken_o,
  output logic                   res_mispredict_o,
  output branch_pkg::word_t      res_pc_o,
  output branch_pkg::word_t      res_next_pc_o,
  output branch_pkg::word_t      res_link_o
);

  import branch_pkg::*;

  // Output register occupancy
  typedef enum logic {
    RES_EMPTY,
    RES_FULL
  } res_state_t;

  res_state_t state_q;
  res_state_t state_d;

  // Handshake events
  logic accept;
  logic consume;

  // Prediction check terms
  logic  wrong_dir;
  logic  wrong_target;
  logic  mispredict;
  word_t next_pc;

  // Ready when empty, or when the held result leaves this cycle
  assign ops_ready_o = (state_q == RES_EMPTY) || res_ready_i;
  assign res_valid_o = (state_q == RES_FULL);

  assign accept  = ops_valid_i && ops_ready_o;
  assign consume = res_valid_o && res_ready_i;

  // Direction mismatch
  assign wrong_dir = (pred_taken_i != calc.taken);

  // Target only matters when both agree on taken
  assign wrong_target = pred_taken_i && calc.taken && (pred_target_i != calc.target);

  assign mispredict = wrong_dir || wrong_target;

  // Architecturally correct successor
  assign next_pc = calc.taken ? calc.target : calc.fall_through;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      RES_EMPTY: begin
        if (accept) begin
          state_d = RES_FULL;
        end
      end
      RES_FULL: begin
        // A new instruction refills in the same cycle the old one leaves
        if (accept) begin
          state_d = RES_FULL;
        end else if (consume) begin
          state_d = RES_EMPTY;
        end
      end
      default: state_d = RES_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= RES_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Result payload
  // Loads only on acceptance, so it holds while the consumer stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      res_pc_o         <= pc_i;
      res_next_pc_o    <= next_pc;
      res_link_o       <= calc.link;
      res_taken_o      <= calc.taken;
      res_mispredict_o <= mispredict;
    end
  end

endmodule

`default_nettype wire

/* source/branch_target_calc.sv */
// Combinational adders forming the jump target and the link address of a control transfer

`timescale 1ns/1ps
`default_nettype none

`include "branch_settings.svh"

module branch_target_calc (
  input  wire branch_pkg::word_t      rs1_i,
  input  wire branch_pkg::word_t      imm_i,
  input  wire branch_pkg::word_t      pc_i,
  input  wire branch_pkg::branch_op_t op_i,
  branch_calc_if.calc                 calc
);

  import branch_pkg::*;

  // Register-relative jump select
  logic  is_jalr;
  // Adder operand and raw sum
  word_t target_base;
  word_t target_sum;
  // PC of the next sequential instruction
  word_t pc_next_seq;

  assign is_jalr = (op_i == BR_JALR);

  // JALR adds to rs1, branches and JAL add to the PC
  assign target_base = is_jalr ? rs1_i : pc_i;

  // Immediate already sign-extended and in bytes
  assign target_sum = target_base + imm_i;

  // JALR drops the low bit of the sum
  always_comb begin
    calc.target = target_sum;
    if (is_jalr) begin
      calc.target[0] = 1'b0;
    end
  end

  // Sequential successor of this instruction
  assign pc_next_seq = pc_i + word_t'(`BRANCH_ILEN_BYTES);

  // Same address serves as return address and not-taken path
  assign calc.link         = pc_next_seq;
  assign calc.fall_through = pc_next_seq;

endmodule

`default_nettype wire

/* source/branch_cond_eval.sv */
// Combinational condition evaluator deciding whether a control-transfer instruction is taken

`timescale 1ns/1ps
`default_nettype none

module branch_cond_eval (
  input  wire branch_pkg::word_t      rs1_i,
  input  wire branch_pkg::word_t      rs2_i,
  input  wire branch_pkg::branch_op_t op_i,
  branch_calc_if.eval                 calc
);

  import branch_pkg::*;

  // Shared comparator results
  logic ops_equal;
  logic ops_less_signed;
  logic ops_less_unsigned;

  // One equality and two magnitude compares
  // Each pair of branches picks its own sense
  assign ops_equal         = (rs1_i == rs2_i);
  assign ops_less_signed   = ($signed(rs1_i) < $signed(rs2_i));
  assign ops_less_unsigned = (rs1_i < rs2_i);

  // Direction decision
  always_comb begin
    case (op_i)
      // Equality
      BR_BEQ:  calc.taken = ops_equal;
      BR_BNE:  calc.taken = !ops_equal;
      // Signed order
      BR_BLT:  calc.taken = ops_less_signed;
      BR_BGE:  calc.taken = !ops_less_signed;
      // Unsigned order
      BR_BLTU: calc.taken = ops_less_unsigned;
      BR_BGEU: calc.taken = !ops_less_unsigned;
      // Jumps always redirect
      BR_JAL:  calc.taken = 1'b1;
      BR_JALR: calc.taken = 1'b1;
      // Unused encodings fall through
      default: calc.taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* source/branch_calc_if.sv */
// Bundle carrying evaluator and target calculator results into the resolution control unit

`timescale 1ns/1ps
`default_nettype none

interface branch_calc_if;

  import branch_pkg::*;

  // Actual direction from the condition evaluator
  logic  taken;

  // Jump or branch target from the target calculator
  word_t target;

  // Return address written by JAL and JALR
  word_t link;

  // Sequential next PC when not taken
  word_t fall_through;

  // Condition evaluator side
  modport eval (
    output taken
  );

  // Target calculator side
  modport calc (
    output target,
    output link,
    output fall_through
  );

  // Control unit reads everything
  modport cu (
    input taken,
    input target,
    input link,
    input fall_through
  );

endinterface

`default_nettype wire

/* source/branch_pkg.sv */
// Shared types of the branch unit, imported by every block that needs a word or an operation

`default_nettype none

`include "branch_settings.svh"

package branch_pkg;

  // One datapath word
  // Used for operands, immediates, PCs and targets
  typedef logic [`BRANCH_XLEN-1:0] word_t;

  // Control-transfer operations handled by the unit
  // Six conditional branches first, then the two jumps
  typedef enum logic [`BRANCH_OP_BITS-1:0] {
    // Equality compares
    BR_BEQ  = 4'd0,
    BR_BNE  = 4'd1,
    // Signed order compares
    BR_BLT  = 4'd2,
    BR_BGE  = 4'd3,
    // Unsigned order compares
    BR_BLTU = 4'd4,
    BR_BGEU = 4'd5,
    // Unconditional jumps
    // JAL is PC relative
    BR_JAL  = 4'd6,
    // JALR is relative to rs1
    BR_JALR = 4'd7
  } branch_op_t;

endpackage

`default_nettype wire

/* include/branch_settings.svh */
// Width and instruction-size macros for the branch unit, included by the RTL and the testbench

`ifndef BRANCH_SETTINGS_SVH
`define BRANCH_SETTINGS_SVH

// Data and address width of the RV32 datapath
`define BRANCH_XLEN 32

// Size in bytes of one uncompressed instruction
// Sets the link address and the fall-through address
`define BRANCH_ILEN_BYTES 4

// Width of the branch operation code
`define BRANCH_OP_BITS 4

`endif
